// File: source/mem_pkg.sv
`default_nettype none

package mem_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // word address, not byte address.
    typedef logic [ADDR_W-1:0] addr_t;

    typedef logic [DATA_W-1:0] data_t;

    // per-port manager states.
    typedef enum logic [2:0] {
        INIT          = 3'd0,
        IDLE          = 3'd1,
        READ_REQUEST  = 3'd2,
        WRITE_REQUEST = 3'd3,
        READ          = 3'd4,
        WRITE         = 3'd5,
        WAIT          = 3'd6
    } mem_state_t;

    localparam int DEFAULT_MEM_DEPTH   = 64; // words.
    localparam int DEFAULT_MEM_LATENCY = 2;  // cycles from strobe to ack.

endpackage

`default_nettype wire

// File: source/mem_manager.sv
`timescale 1ns/10ps
`default_nettype none

module mem_manager (
    input  logic               clk,
    input  logic               rst,
    input  logic               mem_read,
    input  logic               mem_write,
    input  mem_pkg::addr_t     address,
    input  mem_pkg::data_t     write_data,
    output mem_pkg::mem_state_t state,
    output logic               done,
    output mem_pkg::data_t     read_data,
    output logic               bus_req,
    output logic               bus_we,
    output mem_pkg::addr_t     bus_addr,
    output mem_pkg::data_t     bus_wdata,
    input  logic               bus_full,
    input  logic               bus_ack,
    input  mem_pkg::data_t     bus_rdata
);
    import mem_pkg::*;

    mem_state_t next_state;
    logic       is_write_q; // remembers the request kind across WAIT.
    logic       active;
    logic       in_xfer;
    logic       start_req;

    assign in_xfer   = (state == READ) || (state == WRITE);
    assign start_req = (state == IDLE) && !done && (mem_read || mem_write);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= INIT;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            INIT: begin
                next_state = IDLE; // first clock out of reset.
            end

            IDLE: begin
                // the done cycle still shows the old request level.
                if (!done) begin
                    if (mem_read) begin
                        next_state = READ_REQUEST;
                    end else if (mem_write) begin
                        next_state = WRITE_REQUEST;
                    end
                end
            end

            READ_REQUEST: begin
                next_state = bus_full ? WAIT : READ;
            end

            WRITE_REQUEST: begin
                next_state = bus_full ? WAIT : WRITE;
            end

            WAIT: begin
                if (!bus_full) begin
                    next_state = is_write_q ? WRITE : READ;
                end
            end

            READ, WRITE: begin
                if (bus_ack) begin
                    next_state = IDLE;
                end
            end

            default: begin
                next_state = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            is_write_q <= 1'b0;
            done       <= 1'b0;
        end else begin
            done <= in_xfer && bus_ack; // one cycle, lines up with read_data.
            if (start_req) begin
                is_write_q <= !mem_read; // read wins when both are high.
            end
        end
    end

    always_ff @(posedge clk) begin
        if ((state == READ) && bus_ack) begin
            read_data <= bus_rdata;
        end
    end

    assign active = (state == READ_REQUEST) || (state == WRITE_REQUEST) ||
                    (state == WAIT) || in_xfer;

    assign bus_req   = active;
    assign bus_we    = active && is_write_q;
    assign bus_addr  = active ? address : '0;
    assign bus_wdata = (active && is_write_q) ? write_data : '0;

endmodule

`default_nettype wire

// File: source/bus_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module bus_arbiter (
    input  logic                clk,
    input  logic                rst,
    input  logic                cpu_req,
    input  logic                cpu_we,
    input  mem_pkg::addr_t      cpu_addr,
    input  mem_pkg::data_t      cpu_wdata,
    input  mem_pkg::mem_state_t cpu_state,
    input  logic                cpu_done,
    output logic                cpu_full,
    input  logic                dma_req,
    input  logic                dma_we,
    input  mem_pkg::addr_t      dma_addr,
    input  mem_pkg::data_t      dma_wdata,
    input  mem_pkg::mem_state_t dma_state,
    input  logic                dma_done,
    output logic                dma_full,
    input  logic                mem_busy,
    output logic                mem_valid,
    output logic                mem_we,
    output mem_pkg::addr_t      mem_addr,
    output mem_pkg::data_t      mem_wdata
);
    import mem_pkg::*;

    logic       lock_q;
    logic       owner_q;    // 0 cpu, 1 dma.
    logic       last_q;     // last winner, same coding.
    mem_state_t cpu_state_q;
    mem_state_t dma_state_q;
    logic       cpu_ask;
    logic       dma_ask;
    logic       lock_live;
    logic       release_now;
    logic       bus_free;
    logic       grant_cpu;
    logic       grant_dma;
    logic       cpu_start;
    logic       dma_start;

    function automatic logic is_xfer(input mem_state_t s);
        return (s == READ) || (s == WRITE);
    endfunction

    function automatic logic is_asking(input mem_state_t s);
        return (s == READ_REQUEST) || (s == WRITE_REQUEST) || (s == WAIT);
    endfunction

    assign cpu_ask = cpu_req && is_asking(cpu_state);
    assign dma_ask = dma_req && is_asking(dma_state);

    // owner's done frees the bus in the same cycle.
    assign release_now = lock_q && (owner_q ? dma_done : cpu_done);
    assign lock_live   = lock_q && !release_now;
    assign bus_free    = !lock_live && !mem_busy;

    assign grant_cpu = bus_free && cpu_ask && (!dma_ask || last_q);
    assign grant_dma = bus_free && dma_ask && !grant_cpu;

    assign cpu_full = !(grant_cpu || (lock_live && !owner_q));
    assign dma_full = !(grant_dma || (lock_live && owner_q));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lock_q      <= 1'b0;
            owner_q     <= 1'b0;
            last_q      <= 1'b1; // cpu wins the first tie.
            cpu_state_q <= INIT;
            dma_state_q <= INIT;
        end else begin
            cpu_state_q <= cpu_state;
            dma_state_q <= dma_state;
            if (grant_cpu) begin
                lock_q  <= 1'b1;
                owner_q <= 1'b0;
                last_q  <= 1'b0;
            end else if (grant_dma) begin
                lock_q  <= 1'b1;
                owner_q <= 1'b1;
                last_q  <= 1'b1;
            end else if (release_now) begin
                lock_q <= 1'b0;
            end
        end
    end

    // entry into READ or WRITE starts the access.
    assign cpu_start = is_xfer(cpu_state) && !is_xfer(cpu_state_q);
    assign dma_start = is_xfer(dma_state) && !is_xfer(dma_state_q);

    assign mem_valid = lock_q && (owner_q ? dma_start : cpu_start);
    assign mem_we    = owner_q ? dma_we : cpu_we;
    assign mem_addr  = owner_q ? dma_addr : cpu_addr;
    assign mem_wdata = owner_q ? dma_wdata : cpu_wdata;

endmodule

`default_nettype wire

// File: source/bus_memory.sv
`timescale 1ns/10ps
`default_nettype none

module bus_memory #(
    parameter int MEM_DEPTH   = mem_pkg::DEFAULT_MEM_DEPTH,
    parameter int MEM_LATENCY = mem_pkg::DEFAULT_MEM_LATENCY
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           mem_valid,
    input  logic           mem_we,
    input  mem_pkg::addr_t mem_addr,
    input  mem_pkg::data_t mem_wdata,
    output logic           mem_busy,
    output logic           mem_ack,
    output mem_pkg::data_t mem_rdata
);
    import mem_pkg::*;

    localparam int IDX_W = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1;
    localparam int CNT_W = $clog2(MEM_LATENCY + 1);

    data_t              mem_array [MEM_DEPTH];
    addr_t              wrap_addr;
    logic [IDX_W-1:0]   idx_q;
    logic               we_q;
    data_t              wdata_q;
    logic               busy_q;
    logic [CNT_W-1:0]   cnt_q;

    assign wrap_addr = mem_addr % MEM_DEPTH; // aliases past the top.

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
            we_q   <= 1'b0;
        end else begin
            if (mem_valid) begin
                busy_q <= 1'b1;
                cnt_q  <= CNT_W'(MEM_LATENCY - 1);
                we_q   <= mem_we;
            end else if (mem_ack) begin
                busy_q <= 1'b0;
            end else if (busy_q) begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    // request fields held for the whole access.
    always_ff @(posedge clk) begin
        if (mem_valid) begin
            idx_q   <= wrap_addr[IDX_W-1:0];
            wdata_q <= mem_wdata;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < MEM_DEPTH; i++) begin
                mem_array[i] <= '0;
            end
        end else if (mem_ack && we_q) begin
            mem_array[idx_q] <= wdata_q; // write lands at the ack.
        end
    end

    assign mem_busy  = busy_q;
    assign mem_ack   = busy_q && (cnt_q == '0);
    assign mem_rdata = mem_array[idx_q]; // old word, write not yet in.

endmodule

`default_nettype wire

// File: source/mem_subsystem.sv
`timescale 1ns/10ps
`default_nettype none

module mem_subsystem #(
    parameter int MEM_DEPTH   = mem_pkg::DEFAULT_MEM_DEPTH,
    parameter int MEM_LATENCY = mem_pkg::DEFAULT_MEM_LATENCY
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                cpu_read,
    input  logic                cpu_write,
    input  mem_pkg::addr_t      cpu_address,
    input  mem_pkg::data_t      cpu_write_data,
    output mem_pkg::mem_state_t cpu_state,
    output logic                cpu_done,
    output mem_pkg::data_t      cpu_read_data,
    input  logic                dma_read,
    input  logic                dma_write,
    input  mem_pkg::addr_t      dma_address,
    input  mem_pkg::data_t      dma_write_data,
    output mem_pkg::mem_state_t dma_state,
    output logic                dma_done,
    output mem_pkg::data_t      dma_read_data
);
    import mem_pkg::*;

    logic  cpu_bus_req;
    logic  cpu_bus_we;
    addr_t cpu_bus_addr;
    data_t cpu_bus_wdata;
    logic  cpu_bus_full;
    logic  dma_bus_req;
    logic  dma_bus_we;
    addr_t dma_bus_addr;
    data_t dma_bus_wdata;
    logic  dma_bus_full;
    logic  mem_valid;
    logic  mem_we;
    addr_t mem_addr;
    data_t mem_wdata;
    logic  mem_busy;
    logic  mem_ack;
    data_t mem_rdata;

    mem_manager u_cpu_manager (
        .clk        (clk),
        .rst        (rst),
        .mem_read   (cpu_read),
        .mem_write  (cpu_write),
        .address    (cpu_address),
        .write_data (cpu_write_data),
        .state      (cpu_state),
        .done       (cpu_done),
        .read_data  (cpu_read_data),
        .bus_req    (cpu_bus_req),
        .bus_we     (cpu_bus_we),
        .bus_addr   (cpu_bus_addr),
        .bus_wdata  (cpu_bus_wdata),
        .bus_full   (cpu_bus_full),
        .bus_ack    (mem_ack),   // shared ack, filtered by state.
        .bus_rdata  (mem_rdata)
    );

    mem_manager u_dma_manager (
        .clk        (clk),
        .rst        (rst),
        .mem_read   (dma_read),
        .mem_write  (dma_write),
        .address    (dma_address),
        .write_data (dma_write_data),
        .state      (dma_state),
        .done       (dma_done),
        .read_data  (dma_read_data),
        .bus_req    (dma_bus_req),
        .bus_we     (dma_bus_we),
        .bus_addr   (dma_bus_addr),
        .bus_wdata  (dma_bus_wdata),
        .bus_full   (dma_bus_full),
        .bus_ack    (mem_ack),
        .bus_rdata  (mem_rdata)
    );

    bus_arbiter u_bus_arbiter (
        .clk       (clk),
        .rst       (rst),
        .cpu_req   (cpu_bus_req),
        .cpu_we    (cpu_bus_we),
        .cpu_addr  (cpu_bus_addr),
        .cpu_wdata (cpu_bus_wdata),
        .cpu_state (cpu_state),
        .cpu_done  (cpu_done),
        .cpu_full  (cpu_bus_full),
        .dma_req   (dma_bus_req),
        .dma_we    (dma_bus_we),
        .dma_addr  (dma_bus_addr),
        .dma_wdata (dma_bus_wdata),
        .dma_state (dma_state),
        .dma_done  (dma_done),
        .dma_full  (dma_bus_full),
        .mem_busy  (mem_busy),
        .mem_valid (mem_valid),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata)
    );

    bus_memory #(
        .MEM_DEPTH   (MEM_DEPTH),
        .MEM_LATENCY (MEM_LATENCY)
    ) u_bus_memory (
        .clk       (clk),
        .rst       (rst),
        .mem_valid (mem_valid),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_busy  (mem_busy),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

endmodule

`default_nettype wire

// File: test/mem_subsystem_tb.sv
`timescale 1ns/10ps
`default_nettype none

module mem_subsystem_tb;
    import mem_pkg::*;

    localparam int DEPTH   = DEFAULT_MEM_DEPTH;
    localparam int TIMEOUT = 100; // cycles per wait.

    logic       clk;
    logic       rst;
    logic       cpu_read;
    logic       cpu_write;
    addr_t      cpu_address;
    data_t      cpu_write_data;
    mem_state_t cpu_state;
    logic       cpu_done;
    data_t      cpu_read_data;
    logic       dma_read;
    logic       dma_write;
    addr_t      dma_address;
    data_t      dma_write_data;
    mem_state_t dma_state;
    logic       dma_done;
    data_t      dma_read_data;

    data_t  ref_mem [DEPTH];
    int     mismatch_count;
    int     failure_count;
    int     done_count;
    logic   saw_wait;
    integer seed;

    mem_subsystem u_mem_subsystem (
        .clk            (clk),
        .rst            (rst),
        .cpu_read       (cpu_read),
        .cpu_write      (cpu_write),
        .cpu_address    (cpu_address),
        .cpu_write_data (cpu_write_data),
        .cpu_state      (cpu_state),
        .cpu_done       (cpu_done),
        .cpu_read_data  (cpu_read_data),
        .dma_read       (dma_read),
        .dma_write      (dma_write),
        .dma_address    (dma_address),
        .dma_write_data (dma_write_data),
        .dma_state      (dma_state),
        .dma_done       (dma_done),
        .dma_read_data  (dma_read_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // word last written at the aliased address, zero if none.
    function automatic data_t expected_read(input addr_t a);
        return ref_mem[a % DEPTH];
    endfunction

    task automatic check_value(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            mismatch_count++;
        end
    endtask

    // compare process, sampled mid-cycle.
    always @(negedge clk) begin
        if (!rst) begin
            if (cpu_done) begin
                done_count++;
                if (cpu_read) begin
                    check_value("cpu_read_data", cpu_read_data, expected_read(cpu_address));
                end else begin
                    ref_mem[cpu_address % DEPTH] = cpu_write_data;
                end
            end
            if (dma_done) begin
                done_count++;
                if (dma_read) begin
                    check_value("dma_read_data", dma_read_data, expected_read(dma_address));
                end else begin
                    ref_mem[dma_address % DEPTH] = dma_write_data;
                end
            end
            if ((cpu_state == WAIT && (dma_state == READ || dma_state == WRITE)) ||
                (dma_state == WAIT && (cpu_state == READ || cpu_state == WRITE))) begin
                saw_wait = 1'b1;
            end
        end
    end

    task automatic cpu_transfer(input logic wr, input addr_t a, input data_t d);
        int n;
        cpu_read       = !wr;
        cpu_write      = wr;
        cpu_address    = a;
        cpu_write_data = d;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!cpu_done && n < TIMEOUT);
        if (!cpu_done) begin
            $display("cpu request at address %h never finished", a);
            failure_count++;
        end
        @(posedge clk);
        #1;
        cpu_read  = 1'b0;
        cpu_write = 1'b0;
    endtask

    task automatic dma_transfer(input logic wr, input addr_t a, input data_t d);
        int n;
        dma_read       = !wr;
        dma_write      = wr;
        dma_address    = a;
        dma_write_data = d;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!dma_done && n < TIMEOUT);
        if (!dma_done) begin
            $display("dma request at address %h never finished", a);
            failure_count++;
        end
        @(posedge clk);
        #1;
        dma_read  = 1'b0;
        dma_write = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        if (n > 0) begin
            repeat (n) @(posedge clk);
            #1;
        end
    endtask

    initial begin
        int n;
        seed           = 32'h2449_1677;
        rst            = 1'b1;
        cpu_read       = 1'b0;
        cpu_write      = 1'b0;
        cpu_address    = '0;
        cpu_write_data = '0;
        dma_read       = 1'b0;
        dma_write      = 1'b0;
        dma_address    = '0;
        dma_write_data = '0;
        mismatch_count = 0;
        failure_count  = 0;
        done_count     = 0;
        saw_wait       = 1'b0;
        for (int i = 0; i < DEPTH; i++) begin
            ref_mem[i] = '0;
        end
        repeat (3) @(posedge clk);
        #1;
        if (cpu_state != INIT || dma_state != INIT || cpu_done || dma_done) begin
            $display("states not INIT or done high during reset");
            failure_count++;
        end
        rst = 1'b0;

        n = 0;
        while ((cpu_state != IDLE || dma_state != IDLE) && n < TIMEOUT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (cpu_state != IDLE || dma_state != IDLE) begin
            $display("managers did not reach IDLE after reset");
            failure_count++;
        end
        idle_cycles(4);
        if (done_count != 0) begin
            $display("done pulsed before any request");
            failure_count++;
        end

        // write then read back, and an untouched word.
        cpu_transfer(1'b1, 32'd3, 32'hcafe_0003);
        cpu_transfer(1'b0, 32'd3, '0);
        cpu_transfer(1'b0, 32'd9, '0);

        // one memory behind both ports.
        dma_transfer(1'b1, 32'd40, 32'hd0a0_0040);
        cpu_transfer(1'b0, 32'd40, '0);

        // same-cycle requests, one port must wait.
        saw_wait = 1'b0;
        fork
            cpu_transfer(1'b1, 32'd11, 32'h1111_aaaa);
            dma_transfer(1'b1, 32'd50, 32'h5050_bbbb);
        join
        if (!saw_wait) begin
            $display("no port was seen waiting during a bus conflict");
            failure_count++;
        end
        cpu_transfer(1'b0, 32'd50, '0);
        dma_transfer(1'b0, 32'd11, '0);

        // random overlapping traffic, split address halves.
        fork
            for (int i = 0; i < 100; i++) begin
                idle_cycles($unsigned($random(seed)) % 4);
                cpu_transfer(1'($random(seed)), $unsigned($random(seed)) % (DEPTH / 2),
                             $random(seed));
            end
            for (int i = 0; i < 100; i++) begin
                idle_cycles($unsigned($random(seed)) % 4);
                dma_transfer(1'($random(seed)),
                             DEPTH / 2 + $unsigned($random(seed)) % (DEPTH / 2),
                             $random(seed));
            end
        join

        // alias past the top of the array.
        cpu_transfer(1'b1, DEPTH + 5, 32'h0a11_a5e5);
        dma_transfer(1'b0, 32'd5, '0);
        dma_transfer(1'b1, 32'd6, 32'h0b22_b6b6);
        cpu_transfer(1'b0, 2 * DEPTH + 6, '0);

        idle_cycles(4);
        $display("mismatches: %0d, other failures: %0d", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
source/mem_pkg.sv
source/mem_manager.sv
source/bus_arbiter.sv
source/bus_memory.sv
source/mem_subsystem.sv
test/mem_subsystem_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator; exit status follows the result.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wall -Wno-fatal \
    --top-module mem_subsystem_tb -f files.f \
    -o mem_subsystem_sim > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }

./obj_dir/mem_subsystem_sim > sim.log 2>&1 || { echo "run aborted"; exit 1; }

grep -q "Simulation failed" sim.log && { cat sim.log; echo "FAIL"; exit 1; }
grep -q "Simulation completed successfully" sim.log \
    && { echo "PASS"; exit 0; } \
    || { cat sim.log; echo "FAIL"; exit 1; }
